/* source/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

	localparam int byte_w = 8;
	localparam int addr_w = 16;

	// supported opcodes, everything else is skipped
	typedef enum logic [7:0] {
		op_nop  = 8'h12,
		op_bra  = 8'h20,
		op_bne  = 8'h26,
		op_beq  = 8'h27,
		op_suba = 8'h80,
		op_anda = 8'h84,
		op_lda  = 8'h86,
		op_eora = 8'h88,
		op_ora  = 8'h8a,
		op_adda = 8'h8b,
		op_sta  = 8'hb7,
		op_subb = 8'hc0,
		op_andb = 8'hc4,
		op_ldb  = 8'hc6,
		op_eorb = 8'hc8,
		op_orb  = 8'hca,
		op_addb = 8'hcb,
		op_stb  = 8'hf7
	} opcode_e;

	typedef enum logic [2:0] {
		alu_load,
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_eor
	} alu_op_e;

	typedef enum logic {
		acc_a,
		acc_b
	} acc_sel_e;

	localparam logic [15:0] reset_vector_hi = 16'hfffe;
	localparam logic [15:0] reset_vector_lo = 16'hffff;

	// bit positions inside the condition code register
	localparam int flag_c = 0;
	localparam int flag_v = 1;
	localparam int flag_z = 2;
	localparam int flag_n = 3;

endpackage

`default_nettype wire

/* source/cpu_seq_pkg.sv */
`default_nettype none

package cpu_seq_pkg;

	typedef enum logic [4:0] {
		st_vec_hi,        // reset state, address already at the vector
		st_vec_lo,
		st_vec_load,
		st_fetch_addr,
		st_fetch_strobe,
		st_fetch_capture,
		st_decode,
		st_oph_addr,
		st_oph_strobe,
		st_oph_capture,
		st_opl_addr,
		st_opl_strobe,
		st_opl_capture,
		st_execute,
		st_store_addr,
		st_store_strobe,
		st_store_done,
		st_branch
	} seq_state_e;

	typedef enum logic [1:0] {
		sel_pc,
		sel_vector_hi,
		sel_vector_lo,
		sel_ea
	} addr_sel_e;

endpackage

`default_nettype wire

/* source/cpu_alu8.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_alu8(
	input  logic [7:0]           a_i,
	input  logic [7:0]           b_i,
	input  cpu_isa_pkg::alu_op_e op_i,
	input  logic [7:0]           flags_i,
	output logic [7:0]           result_o,
	output logic [7:0]           flags_o
	);

	logic [8:0] sum; // bit 8 is carry or borrow

	always_comb
	begin
		sum = 9'h000;
		flags_o = flags_i;
		result_o = b_i;
		case (op_i)
			cpu_isa_pkg::alu_add:
			begin
				sum = {1'b0, a_i} + {1'b0, b_i};
				result_o = sum[7:0];
				flags_o[cpu_isa_pkg::flag_c] = sum[8];
				flags_o[cpu_isa_pkg::flag_v] = (a_i[7] == b_i[7]) && (sum[7] != a_i[7]);
			end
			cpu_isa_pkg::alu_sub:
			begin
				sum = {1'b0, a_i} - {1'b0, b_i};
				result_o = sum[7:0];
				flags_o[cpu_isa_pkg::flag_c] = sum[8];
				flags_o[cpu_isa_pkg::flag_v] = (a_i[7] != b_i[7]) && (sum[7] != a_i[7]);
			end
			cpu_isa_pkg::alu_and:
				result_o = a_i & b_i;
			cpu_isa_pkg::alu_or:
				result_o = a_i | b_i;
			cpu_isa_pkg::alu_eor:
				result_o = a_i ^ b_i;
			default:
				result_o = b_i; // load
		endcase
		if (op_i != cpu_isa_pkg::alu_add && op_i != cpu_isa_pkg::alu_sub)
			flags_o[cpu_isa_pkg::flag_v] = 1'b0; // logic ops and load clear V, keep C
		flags_o[cpu_isa_pkg::flag_n] = result_o[7];
		flags_o[cpu_isa_pkg::flag_z] = (result_o == 8'h00);
	end

endmodule

`default_nettype wire

/* source/cpu_acc_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_acc_regs(
	input  logic                  cpu_clk,
	input  logic                  k_reset,
	input  logic                  write_i,
	input  cpu_isa_pkg::acc_sel_e sel_i,
	input  logic [7:0]            result_i,
	input  logic [7:0]            flags_i,
	output logic [7:0]            acc_o,
	output logic [7:0]            cc_o
	);

	logic [7:0] acc_a_q, acc_b_q, cc_q;

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			acc_a_q <= 8'h00;
			acc_b_q <= 8'h00;
			cc_q <= 8'h00;
		end
		else if (write_i)
		begin
			if (sel_i == cpu_isa_pkg::acc_b)
				acc_b_q <= result_i;
			else
				acc_a_q <= result_i;
			cc_q <= flags_i; // flags follow every accumulator write
		end
	end

	assign acc_o = (sel_i == cpu_isa_pkg::acc_b) ? acc_b_q : acc_a_q;
	assign cc_o = cc_q;

endmodule

`default_nettype wire

/* source/cpu_pc_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_pc_unit(
	input  logic        cpu_clk,
	input  logic        k_reset,
	input  logic        inc_i,
	input  logic        load_vector_i,
	input  logic        branch_i,
	input  logic [7:0]  operand_hi_i,
	input  logic [7:0]  operand_lo_i,
	output logic [15:0] pc_o
	);

	logic [15:0] pc_q;

	// taken branch shows the target right away so the bus port can latch it
	assign pc_o = branch_i ? pc_q + {{8{operand_lo_i[7]}}, operand_lo_i} : pc_q;

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
			pc_q <= 16'h0000;
		else if (load_vector_i)
			pc_q <= {operand_hi_i, operand_lo_i};
		else if (branch_i)
			pc_q <= pc_o;
		else if (inc_i)
			pc_q <= pc_q + 16'h0001;
	end

endmodule

`default_nettype wire

/* source/cpu_bus_port.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_bus_port(
	input  logic                   cpu_clk,
	input  logic                   k_reset,
	input  cpu_seq_pkg::addr_sel_e addr_sel_i,
	input  logic                   addr_load_i,
	input  logic                   oe_pulse_i,
	input  logic                   we_pulse_i,
	input  logic                   capture_op_i,
	input  logic                   capture_hi_i,
	input  logic                   capture_lo_i,
	input  logic [15:0]            pc_i,
	input  logic [7:0]             store_data_i,
	input  logic [7:0]             cpu_data_i,
	output logic [15:0]            cpu_addr_o,
	output logic [7:0]             cpu_data_o,
	output logic                   cpu_oe_o,
	output logic                   cpu_we_o,
	output logic [7:0]             opcode_o,
	output logic [7:0]             operand_hi_o,
	output logic [7:0]             operand_lo_o
	);

	logic [15:0] addr_d;

	always_comb
	begin
		case (addr_sel_i)
			cpu_seq_pkg::sel_vector_hi: addr_d = cpu_isa_pkg::reset_vector_hi;
			cpu_seq_pkg::sel_vector_lo: addr_d = cpu_isa_pkg::reset_vector_lo;
			cpu_seq_pkg::sel_ea:        addr_d = {operand_hi_o, operand_lo_o};
			default:                    addr_d = pc_i;
		endcase
	end

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			cpu_addr_o <= cpu_isa_pkg::reset_vector_hi; // first read goes to the vector
			cpu_oe_o <= 1'b0;
			cpu_we_o <= 1'b0;
		end
		else
		begin
			cpu_oe_o <= oe_pulse_i; // one cycle strobes
			cpu_we_o <= we_pulse_i;
			if (addr_load_i)
				cpu_addr_o <= addr_d;
		end
	end

	always_ff @(posedge cpu_clk)
	begin
		if (we_pulse_i)
			cpu_data_o <= store_data_i;
		if (capture_op_i)
			opcode_o <= cpu_data_i;
		if (capture_hi_i)
			operand_hi_o <= cpu_data_i;
		if (capture_lo_i)
			operand_lo_o <= cpu_data_i;
	end

endmodule

`default_nettype wire

/* source/cpu_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_sequencer(
	input  logic                   cpu_clk,
	input  logic                   k_reset,
	input  logic [7:0]             opcode_i,
	input  logic [7:0]             flags_i,
	output cpu_seq_pkg::addr_sel_e addr_sel_o,
	output logic                   addr_load_o,
	output logic                   oe_pulse_o,
	output logic                   we_pulse_o,
	output logic                   capture_op_o,
	output logic                   capture_hi_o,
	output logic                   capture_lo_o,
	output logic                   pc_inc_o,
	output logic                   pc_load_vector_o,
	output logic                   pc_branch_o,
	output logic                   acc_write_o,
	output cpu_isa_pkg::acc_sel_e  acc_sel_o,
	output cpu_isa_pkg::alu_op_e   alu_op_o
	);

	cpu_seq_pkg::seq_state_e state_q, state_d;
	logic vec_mode_q; // set while the reset vector is read
	logic is_alu, is_store, is_branch, branch_taken;

	// opcode decoder
	always_comb
	begin
		is_alu = 1'b0;
		is_store = 1'b0;
		is_branch = 1'b0;
		branch_taken = 1'b0;
		alu_op_o = cpu_isa_pkg::alu_load;
		acc_sel_o = opcode_i[6] ? cpu_isa_pkg::acc_b : cpu_isa_pkg::acc_a; // 8x/Bx is A, Cx/Fx is B
		case (opcode_i)
			cpu_isa_pkg::op_lda, cpu_isa_pkg::op_ldb:
				is_alu = 1'b1;
			cpu_isa_pkg::op_adda, cpu_isa_pkg::op_addb:
			begin
				is_alu = 1'b1;
				alu_op_o = cpu_isa_pkg::alu_add;
			end
			cpu_isa_pkg::op_suba, cpu_isa_pkg::op_subb:
			begin
				is_alu = 1'b1;
				alu_op_o = cpu_isa_pkg::alu_sub;
			end
			cpu_isa_pkg::op_anda, cpu_isa_pkg::op_andb:
			begin
				is_alu = 1'b1;
				alu_op_o = cpu_isa_pkg::alu_and;
			end
			cpu_isa_pkg::op_ora, cpu_isa_pkg::op_orb:
			begin
				is_alu = 1'b1;
				alu_op_o = cpu_isa_pkg::alu_or;
			end
			cpu_isa_pkg::op_eora, cpu_isa_pkg::op_eorb:
			begin
				is_alu = 1'b1;
				alu_op_o = cpu_isa_pkg::alu_eor;
			end
			cpu_isa_pkg::op_sta, cpu_isa_pkg::op_stb:
				is_store = 1'b1;
			cpu_isa_pkg::op_bra:
			begin
				is_branch = 1'b1;
				branch_taken = 1'b1;
			end
			cpu_isa_pkg::op_bne:
			begin
				is_branch = 1'b1;
				branch_taken = ~flags_i[cpu_isa_pkg::flag_z];
			end
			cpu_isa_pkg::op_beq:
			begin
				is_branch = 1'b1;
				branch_taken = flags_i[cpu_isa_pkg::flag_z];
			end
			cpu_isa_pkg::op_nop: ; // fetched and skipped
			default: ;
		endcase
	end

	always_comb
	begin
		state_d = state_q;
		addr_sel_o = cpu_seq_pkg::sel_pc;
		addr_load_o = 1'b0;
		oe_pulse_o = 1'b0;
		we_pulse_o = 1'b0;
		capture_op_o = 1'b0;
		capture_hi_o = 1'b0;
		capture_lo_o = 1'b0;
		pc_inc_o = 1'b0;
		pc_load_vector_o = 1'b0;
		pc_branch_o = 1'b0;
		acc_write_o = 1'b0;
		case (state_q)
			cpu_seq_pkg::st_vec_hi:
			begin
				addr_sel_o = cpu_seq_pkg::sel_vector_hi;
				addr_load_o = 1'b1;
				oe_pulse_o = 1'b1;
				state_d = cpu_seq_pkg::st_oph_strobe;
			end
			cpu_seq_pkg::st_vec_lo:
			begin
				oe_pulse_o = 1'b1;
				state_d = cpu_seq_pkg::st_opl_strobe;
			end
			cpu_seq_pkg::st_vec_load:
			begin
				pc_load_vector_o = 1'b1;
				addr_sel_o = cpu_seq_pkg::sel_ea; // vector bytes sit in the operand latches
				addr_load_o = 1'b1;
				state_d = cpu_seq_pkg::st_fetch_addr;
			end
			cpu_seq_pkg::st_fetch_addr:
			begin
				oe_pulse_o = 1'b1;
				state_d = cpu_seq_pkg::st_fetch_strobe;
			end
			cpu_seq_pkg::st_fetch_strobe:
			begin
				pc_inc_o = 1'b1;
				state_d = cpu_seq_pkg::st_fetch_capture;
			end
			cpu_seq_pkg::st_fetch_capture:
			begin
				capture_op_o = 1'b1;
				state_d = cpu_seq_pkg::st_decode;
			end
			cpu_seq_pkg::st_decode:
			begin
				addr_load_o = 1'b1; // next byte of the stream or next opcode
				if (is_store)
					state_d = cpu_seq_pkg::st_oph_addr;
				else if (is_alu || is_branch)
					state_d = cpu_seq_pkg::st_opl_addr;
				else
					state_d = cpu_seq_pkg::st_fetch_addr;
			end
			cpu_seq_pkg::st_oph_addr:
			begin
				oe_pulse_o = 1'b1;
				state_d = cpu_seq_pkg::st_oph_strobe;
			end
			cpu_seq_pkg::st_oph_strobe:
			begin
				pc_inc_o = ~vec_mode_q;
				state_d = cpu_seq_pkg::st_oph_capture;
			end
			cpu_seq_pkg::st_oph_capture:
			begin
				capture_hi_o = 1'b1;
				addr_load_o = 1'b1;
				if (vec_mode_q)
				begin
					addr_sel_o = cpu_seq_pkg::sel_vector_lo;
					state_d = cpu_seq_pkg::st_vec_lo;
				end
				else
					state_d = cpu_seq_pkg::st_opl_addr;
			end
			cpu_seq_pkg::st_opl_addr:
			begin
				oe_pulse_o = 1'b1;
				state_d = cpu_seq_pkg::st_opl_strobe;
			end
			cpu_seq_pkg::st_opl_strobe:
			begin
				pc_inc_o = ~vec_mode_q;
				state_d = cpu_seq_pkg::st_opl_capture;
			end
			cpu_seq_pkg::st_opl_capture:
			begin
				capture_lo_o = 1'b1;
				if (vec_mode_q)
					state_d = cpu_seq_pkg::st_vec_load;
				else if (is_store)
					state_d = cpu_seq_pkg::st_store_addr;
				else if (is_branch)
					state_d = cpu_seq_pkg::st_branch;
				else
					state_d = cpu_seq_pkg::st_execute;
			end
			cpu_seq_pkg::st_execute:
			begin
				acc_write_o = is_alu; // stores pass through here without a write
				addr_load_o = 1'b1;
				state_d = cpu_seq_pkg::st_fetch_addr;
			end
			cpu_seq_pkg::st_store_addr:
			begin
				addr_sel_o = cpu_seq_pkg::sel_ea;
				addr_load_o = 1'b1;
				state_d = cpu_seq_pkg::st_store_strobe;
			end
			cpu_seq_pkg::st_store_strobe:
			begin
				we_pulse_o = 1'b1;
				state_d = cpu_seq_pkg::st_store_done;
			end
			cpu_seq_pkg::st_store_done:
				state_d = cpu_seq_pkg::st_execute;
			cpu_seq_pkg::st_branch:
			begin
				pc_branch_o = branch_taken; // pc_o already shows the target
				addr_load_o = 1'b1;
				state_d = cpu_seq_pkg::st_fetch_addr;
			end
			default:
				state_d = cpu_seq_pkg::st_vec_hi;
		endcase
	end

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			state_q <= cpu_seq_pkg::st_vec_hi;
			vec_mode_q <= 1'b1;
		end
		else
		begin
			state_q <= state_d;
			if (state_q == cpu_seq_pkg::st_vec_load)
				vec_mode_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top(
	input  logic        cpu_clk,
	input  logic        k_reset,
	input  logic [7:0]  cpu_data_i,
	output logic [15:0] cpu_addr_o,
	output logic [7:0]  cpu_data_o,
	output logic        cpu_oe_o,
	output logic        cpu_we_o
	);

	cpu_seq_pkg::addr_sel_e addr_sel;
	cpu_isa_pkg::acc_sel_e  acc_sel;
	cpu_isa_pkg::alu_op_e   alu_op;
	logic        addr_load, oe_pulse, we_pulse;
	logic        capture_op, capture_hi, capture_lo;
	logic        pc_inc, pc_load_vector, pc_branch, acc_write;
	logic [7:0]  opcode, operand_hi, operand_lo;
	logic [7:0]  cc, alu_flags, alu_result, acc;
	logic [15:0] pc;

	cpu_sequencer seq(
		.cpu_clk(cpu_clk),
		.k_reset(k_reset),
		.opcode_i(opcode),
		.flags_i(cc),
		.addr_sel_o(addr_sel),
		.addr_load_o(addr_load),
		.oe_pulse_o(oe_pulse),
		.we_pulse_o(we_pulse),
		.capture_op_o(capture_op),
		.capture_hi_o(capture_hi),
		.capture_lo_o(capture_lo),
		.pc_inc_o(pc_inc),
		.pc_load_vector_o(pc_load_vector),
		.pc_branch_o(pc_branch),
		.acc_write_o(acc_write),
		.acc_sel_o(acc_sel),
		.alu_op_o(alu_op)
	);

	cpu_alu8 alu(
		.a_i(acc),
		.b_i(operand_lo), // immediate operand
		.op_i(alu_op),
		.flags_i(cc),
		.result_o(alu_result),
		.flags_o(alu_flags)
	);

	cpu_acc_regs regs(
		.cpu_clk(cpu_clk),
		.k_reset(k_reset),
		.write_i(acc_write),
		.sel_i(acc_sel),
		.result_i(alu_result),
		.flags_i(alu_flags),
		.acc_o(acc),
		.cc_o(cc)
	);

	cpu_pc_unit pcu(
		.cpu_clk(cpu_clk),
		.k_reset(k_reset),
		.inc_i(pc_inc),
		.load_vector_i(pc_load_vector),
		.branch_i(pc_branch),
		.operand_hi_i(operand_hi),
		.operand_lo_i(operand_lo),
		.pc_o(pc)
	);

	cpu_bus_port bus(
		.cpu_clk(cpu_clk),
		.k_reset(k_reset),
		.addr_sel_i(addr_sel),
		.addr_load_i(addr_load),
		.oe_pulse_i(oe_pulse),
		.we_pulse_i(we_pulse),
		.capture_op_i(capture_op),
		.capture_hi_i(capture_hi),
		.capture_lo_i(capture_lo),
		.pc_i(pc),
		.store_data_i(acc), // selected accumulator for STA/STB
		.cpu_data_i(cpu_data_i),
		.cpu_addr_o(cpu_addr_o),
		.cpu_data_o(cpu_data_o),
		.cpu_oe_o(cpu_oe_o),
		.cpu_we_o(cpu_we_o),
		.opcode_o(opcode),
		.operand_hi_o(operand_hi),
		.operand_lo_o(operand_lo)
	);

endmodule

`default_nettype wire

/* include/cpu_tb_program.svh */
`ifndef CPU_TB_PROGRAM_SVH
`define CPU_TB_PROGRAM_SVH

localparam int k_alu = 0;
localparam int k_store = 1;
localparam int k_branch = 2;
localparam int k_nop = 3;
localparam int k_cond = 4;   // BEQ or BNE right after an ALU op
localparam int k_halt = 5;

int          seed = 32'h4c6a_7a2a;
int          kind [0:n_instr];
logic [15:0] at [0:n_instr]; // start address of each instruction and of the end loop

function automatic int pick(int n);
	return ($random(seed) & 32'h7fff_ffff) % n;
endfunction

// A forms only, bit 6 turns them into the B forms
function automatic logic [7:0] alu_opcode(int n);
	case (n)
		0: return cpu_isa_pkg::op_lda;
		1: return cpu_isa_pkg::op_adda;
		2: return cpu_isa_pkg::op_suba;
		3: return cpu_isa_pkg::op_anda;
		4: return cpu_isa_pkg::op_ora;
		default: return cpu_isa_pkg::op_eora;
	endcase
endfunction

task automatic build_program();
	logic [15:0] a, diff;
	int r, j;
	for (int i = 0; i < 65536; i++)
		mem[i] = i[15:8] ^ i[7:0] ^ 8'h5a; // background pattern from page and offset
	a = prog_base;
	for (int i = 0; i <= n_instr; i++)
	begin
		r = pick(8);
		if (i == n_instr)
			kind[i] = k_halt;
		else if (i > 0 && kind[i - 1] == k_alu && pick(2) == 1)
			kind[i] = k_cond;
		else
			kind[i] = r < 4 ? k_alu : r < 6 ? k_store : r == 6 ? k_branch : k_nop;
		at[i] = a;
		a = a + (kind[i] == k_store ? 16'd3 : kind[i] == k_nop ? 16'd1 : 16'd2);
	end
	for (int i = 0; i <= n_instr; i++)
	begin
		j = i + 2 + pick(7); // forward target past the next instruction
		if (j > n_instr)
			j = n_instr;
		diff = at[j] - at[i] - 16'd2;
		case (kind[i])
			k_alu:
			begin
				mem[at[i]] = alu_opcode(pick(6)) | (pick(2) == 1 ? 8'h40 : 8'h00);
				mem[at[i] + 16'd1] = pick(4) == 0 ? 8'h00 : 8'(pick(256)); // zero often
			end
			k_store:
			begin
				mem[at[i]] = pick(2) == 1 ? cpu_isa_pkg::op_stb : cpu_isa_pkg::op_sta;
				mem[at[i] + 16'd1] = 8'h80;
				mem[at[i] + 16'd2] = 8'(pick(256));
			end
			k_branch, k_cond:
			begin
				r = kind[i] == k_cond ? 1 + pick(2) : pick(3);
				mem[at[i]] = r == 0 ? cpu_isa_pkg::op_bra :
					r == 1 ? cpu_isa_pkg::op_bne : cpu_isa_pkg::op_beq;
				mem[at[i] + 16'd1] = diff[7:0];
			end
			k_nop:
				mem[at[i]] = cpu_isa_pkg::op_nop;
			default:
			begin
				mem[at[i]] = cpu_isa_pkg::op_bra;
				mem[at[i] + 16'd1] = 8'hfe; // end loop branches to itself
			end
		endcase
	end
	mem[16'hfffe] = prog_base[15:8];
	mem[16'hffff] = prog_base[7:0];
endtask

// reference model that walks the program and lists every bus read and write
task automatic run_model();
	logic [15:0] pc;
	logic [7:0]  acc [0:1];
	logic [7:0]  opc, opr, base, res;
	logic        z, taken, is_alu, done;
	int          halt_seen;
	read_q.push_back(16'hfffe);
	read_q.push_back(16'hffff);
	pc = {mem[16'hfffe], mem[16'hffff]};
	acc[0] = 8'h00;
	acc[1] = 8'h00;
	z = 1'b0;
	halt_seen = 0;
	done = 1'b0;
	while (!done)
	begin
		opc = mem[pc];
		opr = mem[pc + 16'd1];
		base = opc & 8'hbf; // fold B forms onto A forms
		is_alu = 1'b1;
		res = 8'h00;
		read_q.push_back(pc);
		if (pc == at[n_instr])
			halt_seen++;
		if (halt_seen == 2)
			done = 1'b1; // second fetch of the end loop
		else
		begin
			case (base)
				cpu_isa_pkg::op_lda:  res = opr;
				cpu_isa_pkg::op_adda: res = acc[opc[6]] + opr;
				cpu_isa_pkg::op_suba: res = acc[opc[6]] - opr;
				cpu_isa_pkg::op_anda: res = acc[opc[6]] & opr;
				cpu_isa_pkg::op_ora:  res = acc[opc[6]] | opr;
				cpu_isa_pkg::op_eora: res = acc[opc[6]] ^ opr;
				cpu_isa_pkg::op_sta:
				begin
					is_alu = 1'b0;
					read_q.push_back(pc + 16'd1);
					read_q.push_back(pc + 16'd2);
					store_q.push_back({opr, mem[pc + 16'd2], acc[opc[6]]});
					pc = pc + 16'd3; // flags untouched
				end
				cpu_isa_pkg::op_bra, cpu_isa_pkg::op_bne, cpu_isa_pkg::op_beq:
				begin
					is_alu = 1'b0;
					read_q.push_back(pc + 16'd1);
					taken = (opc == cpu_isa_pkg::op_bra) ||
						(opc == cpu_isa_pkg::op_bne && !z) ||
						(opc == cpu_isa_pkg::op_beq && z);
					pc = pc + 16'd2;
					if (taken)
						pc = pc + {{8{opr[7]}}, opr}; // relative to the next instruction
				end
				default:
				begin
					is_alu = 1'b0;
					pc = pc + 16'd1; // NOP and unknown opcodes
				end
			endcase
			if (is_alu)
			begin
				read_q.push_back(pc + 16'd1);
				acc[opc[6]] = res;
				z = (res == 8'h00);
				pc = pc + 16'd2;
			end
		end
	end
endtask

`endif

/* test/cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

	localparam int n_instr = 60;
	localparam logic [15:0] prog_base = 16'h0100;

	logic        cpu_clk = 1'b0;
	logic        k_reset;
	logic [7:0]  cpu_data_i;
	logic [15:0] cpu_addr_o;
	logic [7:0]  cpu_data_o;
	logic        cpu_oe_o;
	logic        cpu_we_o;

	logic [7:0]  mem [0:65535];
	logic [15:0] read_q [$];  // expected read addresses in bus order
	logic [23:0] store_q [$]; // expected writes, address and data
	logic [23:0] exp_store;
	logic        oe_prev, we_prev;
	int          cycles, reads, cycle_limit;
	string       read_name;

	`include "cpu_tb_program.svh"

	cpu_top dut(
		.cpu_clk(cpu_clk),
		.k_reset(k_reset),
		.cpu_data_i(cpu_data_i),
		.cpu_addr_o(cpu_addr_o),
		.cpu_data_o(cpu_data_o),
		.cpu_oe_o(cpu_oe_o),
		.cpu_we_o(cpu_we_o)
	);

	always #10 cpu_clk = ~cpu_clk;

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// data appears on the edge that ends the strobe cycle
	always @(posedge cpu_clk)
	begin
		if (cpu_oe_o)
			cpu_data_i <= mem[cpu_addr_o];
		if (cpu_we_o)
			mem[cpu_addr_o] <= cpu_data_o;
	end

	initial
	begin
		k_reset = 1'b1;
		cpu_data_i = 8'h00;
		oe_prev = 1'b0;
		we_prev = 1'b0;
		cycles = 0;
		reads = 0;
		cycle_limit = n_instr * 14 + 200; // slowest instruction plus margin
		build_program();
		run_model();
		repeat (16) @(posedge cpu_clk);
		k_reset <= 1'b0;
	end

	// bus outputs are registered, so the falling edge sees them settled
	always @(negedge cpu_clk)
	begin
		if (k_reset)
		begin
			compare("oe_in_reset", 0, cpu_oe_o);
			compare("we_in_reset", 0, cpu_we_o);
		end
		else
		begin
			cycles = cycles + 1;
			if (cycles > cycle_limit)
			begin
				$display("timeout after %0d cycles, the CPU did not reach the end loop", cycles);
				$display("SIMULATION FAILED");
				$fatal(1, "timeout");
			end
			compare("strobe_overlap", 0, cpu_oe_o & cpu_we_o);
			compare("oe_width", 0, cpu_oe_o & oe_prev);
			compare("we_width", 0, cpu_we_o & we_prev);
			if (reads == 0)
				compare("we_before_first_read", 0, cpu_we_o);
			oe_prev = cpu_oe_o;
			we_prev = cpu_we_o;
			if (cpu_we_o)
			begin
				if (store_q.size() == 0)
				begin
					$display("unexpected write of %h to address %h", cpu_data_o, cpu_addr_o);
					$display("SIMULATION FAILED");
					$fatal(1, "unexpected write");
				end
				exp_store = store_q.pop_front();
				compare("store_addr", exp_store[23:8], cpu_addr_o);
				compare("store_data", exp_store[7:0], cpu_data_o);
			end
			if (cpu_oe_o)
			begin
				if (reads < 2)
					read_name = "vector_read";
				else
					read_name = "read_addr";
				compare(read_name, read_q.pop_front(), cpu_addr_o);
				reads = reads + 1;
				if (read_q.size() == 0)
				begin
					if (store_q.size() != 0)
					begin
						$display("%0d expected stores were never written", store_q.size());
						$display("SIMULATION FAILED");
						$fatal(1, "missing stores");
					end
					else
					begin
						$display("SIMULATION PASSED");
						$finish;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
source/cpu_isa_pkg.sv
source/cpu_seq_pkg.sv
source/cpu_alu8.sv
source/cpu_acc_regs.sv
source/cpu_pc_unit.sv
source/cpu_bus_port.sv
source/cpu_sequencer.sv
source/cpu_top.sv
test/cpu_tb.sv
